//--- run.sh
#!/bin/sh
verilator --binary --timing -f vlog.f --top-module tb_top -o tb_sim \
   && ./obj_dir/tb_sim \
   || exit 1

//--- src/code_store.sv
`default_nettype none

module code_store (
   input  wire                               i_clk,
   input  wire                               i_nrst,
   input  wire ice51_pkg::rx_byte_t          i_byte,
   input  wire [ice51_pkg::CODE_AW-1:0]      i_rd_addr,
   output logic [7:0]                        o_rd_data,
   output logic                              o_load_done
);

logic [7:0]                   mem [ice51_pkg::CODE_DEPTH];
logic [ice51_pkg::CODE_AW-1:0] load_addr;
logic                         wr_en;

assign wr_en = i_byte.valid & ~o_load_done;   // late bytes ignored

// load counter, done latches on wrap
always_ff @(posedge i_clk or negedge i_nrst) begin
   if (!i_nrst) begin
      load_addr   <= '0;
      o_load_done <= 1'b0;
   end else if (wr_en) begin
      load_addr <= load_addr + 1'b1;
      if (load_addr == ice51_pkg::CODE_AW'(ice51_pkg::CODE_DEPTH - 1)) begin
         o_load_done <= 1'b1;
      end
   end
end

always_ff @(posedge i_clk) begin
   if (wr_en) mem[load_addr] <= i_byte.data;
end

assign o_rd_data = mem[i_rd_addr];   // async read

endmodule

`default_nettype wire

//--- src/cpu_datapath.sv
`default_nettype none

module cpu_datapath (
   input  wire                      i_clk,
   input  wire                      i_nrst,
   input  wire ice51_pkg::instr_t   i_instr,
   input  wire                      i_tx_busy,
   output logic                     o_acc_zero,
   output logic [7:0]               o_reg_sel,
   output ice51_pkg::tx_req_t       o_tx_req
);

ice51_pkg::opcode_t op;
logic [4:0]         grp;
logic [2:0]         idx;
logic [7:0]         acc;
logic [7:0]         acc_next;
logic [7:0]         regs [8];
logic [7:0]         reg_sel;
logic [7:0]         reg_wdata;
logic               reg_we;
logic [15:0]        dptr;
logic [7:0]         addend;
logic [7:0]         sum;

assign op      = i_instr.op;
assign grp     = op.rf.grp;   // register forms decode this way
assign idx     = op.rf.idx;
assign reg_sel = regs[idx];

////////////////////
// adder

always_comb begin
   case (op.code)
      ice51_pkg::OP_INCA:  addend = 8'd1;
      ice51_pkg::OP_DECA:  addend = 8'hff;   // minus one
      ice51_pkg::OP_ADDAI: addend = i_instr.arg1;
      default:             addend = reg_sel;   // add a,rn
   endcase
end

assign sum = acc + addend;

////////////////////
// accumulator

always_comb begin
   acc_next = acc;
   case (op.code)
      ice51_pkg::OP_INCA,
      ice51_pkg::OP_DECA,
      ice51_pkg::OP_ADDAI: acc_next = sum;
      ice51_pkg::OP_MOVAI: acc_next = i_instr.arg1;
      ice51_pkg::OP_CLRA:  acc_next = 8'd0;
      ice51_pkg::OP_MOVXAD: begin
         // only the status location reads back
         if (dptr == ice51_pkg::XADDR_TX_STATUS) acc_next = {7'd0, i_tx_busy};
         else acc_next = 8'd0;
      end
      default: begin
         if (grp == ice51_pkg::GRP_ADDAR) acc_next = sum;
         else if (grp == ice51_pkg::GRP_MOVAR) acc_next = reg_sel;
      end
   endcase
end

always_ff @(posedge i_clk or negedge i_nrst) begin
   if (!i_nrst) begin
      acc <= 8'd0;
   end else if (i_instr.exec) begin
      acc <= acc_next;
   end
end

////////////////////
// register bank

always_comb begin
   reg_we    = 1'b1;
   reg_wdata = reg_sel;
   case (grp)
      ice51_pkg::GRP_INCR:  reg_wdata = reg_sel + 8'd1;
      ice51_pkg::GRP_DJNZR: reg_wdata = reg_sel - 8'd1;
      ice51_pkg::GRP_MOVRI: reg_wdata = i_instr.arg1;
      ice51_pkg::GRP_MOVRA: reg_wdata = acc;
      default:              reg_we = 1'b0;
   endcase
end

always_ff @(posedge i_clk) begin
   if (i_instr.exec && reg_we) regs[idx] <= reg_wdata;
end

// dptr, high byte comes first in the code
always_ff @(posedge i_clk or negedge i_nrst) begin
   if (!i_nrst) begin
      dptr <= 16'd0;
   end else if (i_instr.exec && op.code == ice51_pkg::OP_MOVDP) begin
      dptr <= {i_instr.arg1, i_instr.arg2};
   end
end

assign o_acc_zero = (acc == 8'd0);
assign o_reg_sel  = reg_sel;

// writes elsewhere in xdata go nowhere
always_comb begin
   o_tx_req.start = i_instr.exec & (op.code == ice51_pkg::OP_MOVXDA)
                  & (dptr == ice51_pkg::XADDR_TX_DATA);
   o_tx_req.data  = acc;
end

endmodule

`default_nettype wire

//--- src/cpu_sequencer.sv
`default_nettype none

module cpu_sequencer (
   input  wire                             i_clk,
   input  wire                             i_nrst,
   input  wire                             i_load_done,
   input  wire [7:0]                       i_code,
   output logic [ice51_pkg::CODE_AW-1:0]   o_code_addr,
   input  wire                             i_acc_zero,
   input  wire [7:0]                       i_reg_sel,
   output ice51_pkg::instr_t               o_instr
);

localparam logic [2:0] ST_FETCH = 3'd0;
localparam logic [2:0] ST_DEC0  = 3'd1;
localparam logic [2:0] ST_DEC1  = 3'd2;
localparam logic [2:0] ST_DEC2  = 3'd3;
localparam logic [2:0] ST_EXEC  = 3'd4;

logic [2:0]                    state;
logic [ice51_pkg::CODE_AW-1:0] pc;
ice51_pkg::opcode_t            op_q;
logic [7:0]                    arg1_q;
logic [7:0]                    arg2_q;
logic [ice51_pkg::CODE_AW-1:0] rel_target;
logic [ice51_pkg::CODE_AW-1:0] abs_target;
logic                          take_rel;
logic                          take_abs;

// byte count, anything unknown is a one byte nop
function automatic logic [1:0] instr_len(input ice51_pkg::opcode_t op);
   logic [1:0] len;
   len = 2'd1;
   case (op.code)
      ice51_pkg::OP_LJMP,
      ice51_pkg::OP_MOVDP: len = 2'd3;
      ice51_pkg::OP_ADDAI,
      ice51_pkg::OP_JZ,
      ice51_pkg::OP_JNZ,
      ice51_pkg::OP_MOVAI,
      ice51_pkg::OP_SJMP: len = 2'd2;
      default: ;
   endcase
   if (op.rf.grp == ice51_pkg::GRP_MOVRI || op.rf.grp == ice51_pkg::GRP_DJNZR) begin
      len = 2'd2;
   end
   return len;
endfunction

////////////////////
// branch decisions

// pc already points past the instruction here
assign rel_target = pc + {arg1_q[7], arg1_q};
assign abs_target = {arg1_q[0], arg2_q};   // high byte gives bit 8 only

always_comb begin
   take_rel = 1'b0;
   case (op_q.code)
      ice51_pkg::OP_SJMP: take_rel = 1'b1;
      ice51_pkg::OP_JZ:   take_rel = i_acc_zero;
      ice51_pkg::OP_JNZ:  take_rel = ~i_acc_zero;
      default: begin
         // register still holds the old value, so minus one nonzero means != 1
         if (op_q.rf.grp == ice51_pkg::GRP_DJNZR) take_rel = (i_reg_sel != 8'd1);
      end
   endcase
end

assign take_abs = (op_q.code == ice51_pkg::OP_LJMP);

////////////////////
// state, pc, opcode

always_ff @(posedge i_clk or negedge i_nrst) begin
   if (!i_nrst) begin
      state <= ST_FETCH;
      pc    <= '0;
      op_q  <= ice51_pkg::OP_NOP;
   end else begin
      case (state)
         ST_FETCH: begin
            if (i_load_done) state <= ST_DEC0;   // hold until image is in
         end
         ST_DEC0: begin
            op_q  <= i_code;
            pc    <= pc + 1'b1;
            state <= (instr_len(i_code) == 2'd1) ? ST_EXEC : ST_DEC1;
         end
         ST_DEC1: begin
            pc    <= pc + 1'b1;
            state <= (instr_len(op_q) == 2'd3) ? ST_DEC2 : ST_EXEC;
         end
         ST_DEC2: begin
            pc    <= pc + 1'b1;
            state <= ST_EXEC;
         end
         default: begin
            if (take_abs) begin
               pc <= abs_target;
            end else if (take_rel) begin
               pc <= rel_target;   // wraps at 512
            end
            state <= ST_FETCH;
         end
      endcase
   end
end

// operand bytes
always_ff @(posedge i_clk) begin
   if (state == ST_DEC1) arg1_q <= i_code;
   if (state == ST_DEC2) arg2_q <= i_code;
end

assign o_code_addr = pc;

always_comb begin
   o_instr.op   = op_q;
   o_instr.arg1 = arg1_q;
   o_instr.arg2 = arg2_q;
   o_instr.exec = (state == ST_EXEC);
end

endmodule

`default_nettype wire

//--- src/ice51_pkg.sv
`default_nettype none

package ice51_pkg;

   ////////////////////
   // code memory

   localparam int CODE_AW    = 9;
   localparam int CODE_DEPTH = 512;

   ////////////////////
   // opcodes, 8051 encodings

   localparam logic [7:0] OP_NOP    = 8'h00;
   localparam logic [7:0] OP_LJMP   = 8'h02;   // ljmp addr16
   localparam logic [7:0] OP_INCA   = 8'h04;
   localparam logic [7:0] OP_DECA   = 8'h14;
   localparam logic [7:0] OP_ADDAI  = 8'h24;   // add a,#imm
   localparam logic [7:0] OP_JZ     = 8'h60;
   localparam logic [7:0] OP_JNZ    = 8'h70;
   localparam logic [7:0] OP_MOVAI  = 8'h74;   // mov a,#imm
   localparam logic [7:0] OP_SJMP   = 8'h80;
   localparam logic [7:0] OP_MOVDP  = 8'h90;   // mov dptr,#imm16
   localparam logic [7:0] OP_MOVXAD = 8'hE0;   // movx a,@dptr
   localparam logic [7:0] OP_CLRA   = 8'hE4;
   localparam logic [7:0] OP_MOVXDA = 8'hF0;   // movx @dptr,a

   // register forms, upper five bits of the opcode
   localparam logic [4:0] GRP_INCR  = 5'b00001;   // inc rn
   localparam logic [4:0] GRP_ADDAR = 5'b00101;   // add a,rn
   localparam logic [4:0] GRP_MOVRI = 5'b01111;   // mov rn,#imm
   localparam logic [4:0] GRP_DJNZR = 5'b11011;   // djnz rn,rel
   localparam logic [4:0] GRP_MOVAR = 5'b11101;   // mov a,rn
   localparam logic [4:0] GRP_MOVRA = 5'b11111;   // mov rn,a

   ////////////////////
   // movx map

   localparam logic [15:0] XADDR_TX_STATUS = 16'h0200;
   localparam logic [15:0] XADDR_TX_DATA   = 16'h0201;

   ////////////////////
   // types

   typedef struct packed {
      logic [4:0] grp;
      logic [2:0] idx;
   } reg_form_t;

   // same byte, seen whole or as group plus register index
   typedef union packed {
      logic [7:0] code;
      reg_form_t  rf;
   } opcode_t;

   typedef struct packed {
      opcode_t    op;
      logic [7:0] arg1;   // first operand byte
      logic [7:0] arg2;   // second operand byte
      logic       exec;   // one cycle per instruction
   } instr_t;

   typedef struct packed {
      logic       valid;
      logic [7:0] data;
   } rx_byte_t;

   typedef struct packed {
      logic       start;
      logic [7:0] data;
   } tx_req_t;

endpackage

`default_nettype wire

//--- src/ice51_top.sv
`default_nettype none

module ice51_top #(
   parameter int CLKS_PER_BIT = 104
) (
   input  wire   i_clk,
   input  wire   i_nrst,
   input  wire   i_uart_rx,
   output logic  o_uart_tx
);

ice51_pkg::rx_byte_t           rx_byte;
logic [ice51_pkg::CODE_AW-1:0] code_addr;
logic [7:0]                    code_data;
logic                          load_done;
ice51_pkg::instr_t             instr;
logic                          acc_zero;
logic [7:0]                    reg_sel;
ice51_pkg::tx_req_t            tx_req;
logic                          tx_busy;

////////////////////
// loader

uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_i (
   .i_clk  (i_clk),
   .i_nrst (i_nrst),
   .i_rx   (i_uart_rx),
   .o_byte (rx_byte)
);

code_store code_store_i (
   .i_clk       (i_clk),
   .i_nrst      (i_nrst),
   .i_byte      (rx_byte),
   .i_rd_addr   (code_addr),
   .o_rd_data   (code_data),
   .o_load_done (load_done)
);

////////////////////
// core

cpu_sequencer cpu_sequencer_i (
   .i_clk       (i_clk),
   .i_nrst      (i_nrst),
   .i_load_done (load_done),
   .i_code      (code_data),
   .o_code_addr (code_addr),
   .i_acc_zero  (acc_zero),
   .i_reg_sel   (reg_sel),
   .o_instr     (instr)
);

cpu_datapath cpu_datapath_i (
   .i_clk      (i_clk),
   .i_nrst     (i_nrst),
   .i_instr    (instr),
   .i_tx_busy  (tx_busy),
   .o_acc_zero (acc_zero),
   .o_reg_sel  (reg_sel),
   .o_tx_req   (tx_req)
);

uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_i (
   .i_clk  (i_clk),
   .i_nrst (i_nrst),
   .i_req  (tx_req),
   .o_tx   (o_uart_tx),
   .o_busy (tx_busy)
);

endmodule

`default_nettype wire

//--- src/uart_rx.sv
`default_nettype none

module uart_rx #(
   parameter int CLKS_PER_BIT = 104
) (
   input  wire                  i_clk,
   input  wire                  i_nrst,
   input  wire                  i_rx,
   output ice51_pkg::rx_byte_t  o_byte
);

localparam int CW = $clog2(CLKS_PER_BIT);

localparam logic [1:0] ST_IDLE  = 2'd0;
localparam logic [1:0] ST_START = 2'd1;
localparam logic [1:0] ST_RECV  = 2'd2;
localparam logic [1:0] ST_STOP  = 2'd3;

logic [2:0]    rx_sync;
logic          rx_s;
logic          rx_fall;
logic [1:0]    state;
logic [CW-1:0] cnt;
logic [7:0]    shreg;
logic          valid;
logic          half_hit;
logic          full_hit;

// line resync, top bit only used for edge detect
always_ff @(posedge i_clk or negedge i_nrst) begin
   if (!i_nrst) begin
      rx_sync <= 3'b111;
   end else begin
      rx_sync <= {rx_sync[1:0], i_rx};
   end
end

assign rx_s     = rx_sync[1];
assign rx_fall  = rx_sync[2] & ~rx_sync[1];
assign half_hit = (cnt == CW'(CLKS_PER_BIT / 2 - 1));
assign full_hit = (cnt == CW'(CLKS_PER_BIT - 1));

////////////////////
// frame fsm

always_ff @(posedge i_clk or negedge i_nrst) begin
   if (!i_nrst) begin
      state <= ST_IDLE;
      cnt   <= '0;
      shreg <= '0;
      valid <= 1'b0;
   end else begin
      valid <= 1'b0;
      case (state)
         ST_IDLE: begin
            cnt <= '0;
            if (rx_fall) state <= ST_START;
         end
         ST_START: begin
            if (half_hit) begin
               cnt <= '0;
               if (!rx_s) begin
                  state <= ST_RECV;
                  shreg <= 8'h80;   // marker bit
               end else begin
                  state <= ST_IDLE;   // glitch, not a start bit
               end
            end else begin
               cnt <= cnt + 1'b1;
            end
         end
         ST_RECV: begin
            if (full_hit) begin
               cnt   <= '0;
               shreg <= {rx_s, shreg[7:1]};
               // marker at the bottom, this was bit 7
               if (shreg[0]) state <= ST_STOP;
            end else begin
               cnt <= cnt + 1'b1;
            end
         end
         default: begin
            if (full_hit) begin
               cnt   <= '0;
               valid <= rx_s;   // drop frames with a bad stop bit
               state <= ST_IDLE;
            end else begin
               cnt <= cnt + 1'b1;
            end
         end
      endcase
   end
end

always_comb begin
   o_byte.valid = valid;
   o_byte.data  = shreg;
end

endmodule

`default_nettype wire

//--- src/uart_tx.sv
`default_nettype none

module uart_tx #(
   parameter int CLKS_PER_BIT = 104
) (
   input  wire                      i_clk,
   input  wire                      i_nrst,
   input  wire ice51_pkg::tx_req_t  i_req,
   output logic                     o_tx,
   output logic                     o_busy
);

localparam int CW = $clog2(CLKS_PER_BIT);

localparam logic [1:0] ST_IDLE  = 2'd0;
localparam logic [1:0] ST_START = 2'd1;
localparam logic [1:0] ST_SEND  = 2'd2;

logic [1:0]    state;
logic [CW-1:0] cnt;
logic [3:0]    bit_cnt;
logic [7:0]    shreg;
logic          bit_end;

assign bit_end = (cnt == CW'(CLKS_PER_BIT - 1));

////////////////////
// frame fsm

always_ff @(posedge i_clk or negedge i_nrst) begin
   if (!i_nrst) begin
      state   <= ST_IDLE;
      cnt     <= '0;
      bit_cnt <= '0;
   end else begin
      case (state)
         ST_IDLE: begin
            cnt     <= '0;
            bit_cnt <= '0;
            if (i_req.start) state <= ST_START;   // starts while busy are lost
         end
         ST_START: begin
            cnt <= bit_end ? '0 : cnt + 1'b1;
            if (bit_end) state <= ST_SEND;
         end
         default: begin
            if (bit_end) begin
               cnt <= '0;
               // 8 data bits then the stop bit
               if (bit_cnt == 4'd8) state <= ST_IDLE;
               else bit_cnt <= bit_cnt + 1'b1;
            end else begin
               cnt <= cnt + 1'b1;
            end
         end
      endcase
   end
end

// lsb first, ones fill in behind for the stop bit
always_ff @(posedge i_clk) begin
   if (state == ST_IDLE && i_req.start) begin
      shreg <= i_req.data;
   end else if (state == ST_SEND && bit_end) begin
      shreg <= {1'b1, shreg[7:1]};
   end
end

always_comb begin
   case (state)
      ST_IDLE:  o_tx = 1'b1;
      ST_START: o_tx = 1'b0;
      default:  o_tx = shreg[0];
   endcase
end

assign o_busy = (state != ST_IDLE);

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`default_nettype none

module tb_clock #(
   parameter int PERIOD = 8
) (
   output logic o_clk
);

initial o_clk = 1'b0;

always #(PERIOD / 2) o_clk = ~o_clk;   // free running

endmodule

`default_nettype wire

//--- testbench/tb_top.sv
`default_nettype none

module tb_top;

localparam int CLK_PERIOD   = 8;
localparam int CLKS_PER_BIT = 16;
localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT;
localparam int CODE_BYTES   = 512;
localparam int N_TESTS      = 6;
// two full image loads per test, plus some slack
localparam int TIMEOUT = N_TESTS * 2 * CODE_BYTES * FRAME_CLKS * CLK_PERIOD + 100000;

logic       clk;
logic       nrst;
logic       rx_line;
logic       tx_line;
logic       line_watch;   // tx line must idle high while set
logic [8:0] wr_ptr;
logic [7:0] image [CODE_BYTES];
logic [7:0] exp_q [$];

tb_clock #(.PERIOD(CLK_PERIOD)) tb_clock_i (
   .o_clk (clk)
);

ice51_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) dut_i (
   .i_clk     (clk),
   .i_nrst    (nrst),
   .i_uart_rx (rx_line),
   .o_uart_tx (tx_line)
);

////////////////////
// checking

task automatic abort_run();
   $display("Errors found");
   $fatal(1);
endtask

task automatic check(input string name, input logic [7:0] expected, input logic [7:0] actual);
   if (actual !== expected) begin
      $display("MISMATCH at %0t: %s expected 0x%02h, got 0x%02h",
               $time, name, expected, actual);
      abort_run();
   end
endtask

// one negedge, tx line checked if watching
task automatic line_high_check();
   @(negedge clk);
   if (line_watch) check("o_uart_tx", 8'h01, {7'd0, tx_line});
endtask

initial begin
   #(TIMEOUT);
   $display("timeout: the DUT did not finish sending its bytes in time");
   abort_run();
end

////////////////////
// reset and uart driver

task automatic reset_dut();
   @(posedge clk);
   #1;
   nrst = 1'b0;
   repeat (10) begin
      line_high_check();
      @(posedge clk);
   end
   #1;
   nrst = 1'b1;
endtask

// holds one bit for a full bit time
task automatic drive_bit(input logic b);
   @(posedge clk);
   #1;
   rx_line = b;
   repeat (CLKS_PER_BIT - 1) begin
      line_high_check();
      @(posedge clk);
   end
   line_high_check();
endtask

task automatic send_byte(input logic [7:0] b);
   logic [7:0] sh;
   sh = b;
   drive_bit(1'b0);   // start
   repeat (8) begin
      drive_bit(sh[0]);
      sh = sh >> 1;
   end
   drive_bit(1'b1);   // stop
endtask

task automatic send_image();
   int i;
   for (i = 0; i < CODE_BYTES; i++) send_byte(image[9'(i)]);
endtask

////////////////////
// uart monitor

task automatic recv_byte(output logic [7:0] b);
   b = 8'h00;
   @(negedge clk);
   while (tx_line !== 1'b0) @(negedge clk);
   repeat (CLKS_PER_BIT / 2) @(negedge clk);   // middle of start bit
   if (tx_line !== 1'b0) begin
      $display("start bit on o_uart_tx did not last half a bit time at %0t", $time);
      abort_run();
   end
   repeat (8) begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      b = {tx_line, b[7:1]};   // lsb arrives first
   end
   repeat (CLKS_PER_BIT) @(negedge clk);
   if (tx_line !== 1'b1) begin
      $display("stop bit on o_uart_tx was low at %0t", $time);
      abort_run();
   end
endtask

task automatic expect_quiet(input int n);
   repeat (n) begin
      @(negedge clk);
      check("o_uart_tx", 8'h01, {7'd0, tx_line});
   end
endtask

////////////////////
// image building

task automatic clear_image();
   int i;
   for (i = 0; i < CODE_BYTES; i++) image[9'(i)] = 8'h00;   // nop padding
   wr_ptr = 9'd0;
   exp_q.delete();
endtask

task automatic org(input logic [8:0] addr);
   wr_ptr = addr;
endtask

task automatic emit1(input logic [7:0] b0);
   image[wr_ptr] = b0;
   wr_ptr = wr_ptr + 9'd1;
endtask

task automatic emit2(input logic [7:0] b0, input logic [7:0] b1);
   emit1(b0);
   emit1(b1);
endtask

task automatic emit3(input logic [7:0] b0, input logic [7:0] b1, input logic [7:0] b2);
   emit1(b0);
   emit1(b1);
   emit1(b2);
endtask

// relative offset from the address after the branch
function automatic logic [7:0] rel8(input logic [8:0] next_addr, input logic [8:0] target);
   return 8'(target - next_addr);
endfunction

// reset, load with the line watched, then collect the frames
task automatic run_and_compare();
   logic [7:0] got;
   logic [7:0] want;
   line_watch = 1'b1;
   reset_dut();
   send_image();
   line_watch = 1'b0;
   while (exp_q.size() > 0) begin
      want = exp_q.pop_front();
      recv_byte(got);
      check("o_uart_tx byte", want, got);
   end
   expect_quiet(3 * FRAME_CLKS);   // nothing extra
endtask

////////////////////
// directed tests

task automatic test_reset_and_load();
   clear_image();
   emit3(8'h90, 8'h02, 8'h01);   // mov dptr,#0201
   emit1(8'hF0);                 // a is zero out of reset
   emit2(8'h80, 8'hFE);
   exp_q.push_back(8'h00);
   run_and_compare();
endtask

task automatic test_const_tx();
   logic [7:0] imm;
   imm = 8'h5A;
   clear_image();
   emit3(8'h90, 8'h02, 8'h01);
   emit2(8'h74, imm);            // mov a,#imm
   emit1(8'hF0);
   emit2(8'h80, 8'hFE);          // sjmp $
   exp_q.push_back(imm);
   run_and_compare();
endtask

task automatic test_add();
   logic [7:0] x;
   logic [7:0] y;
   logic [7:0] want;
   x = 8'hC8;
   y = 8'h4F;
   want = x + y + 8'd1;          // wraps at 256
   clear_image();
   emit2(8'h7B, x);              // mov r3,#x
   emit2(8'h74, y);
   emit1(8'h2B);                 // add a,r3
   emit1(8'h04);                 // inc a
   emit3(8'h90, 8'h02, 8'h01);
   emit1(8'hF0);
   emit2(8'h80, 8'hFE);
   exp_q.push_back(want);
   run_and_compare();
endtask

task automatic test_reg_moves();
   logic [7:0] y;
   logic [7:0] z;
   logic [7:0] r5;
   y = 8'hFF;
   z = 8'h33;
   r5 = y + 8'd1;                // inc r5 wraps to zero
   clear_image();
   emit2(8'h74, y);
   emit1(8'hFD);                 // mov r5,a
   emit1(8'h0D);                 // inc r5
   emit1(8'hED);                 // mov a,r5
   emit1(8'h14);                 // dec a
   emit2(8'h24, z);              // add a,#z
   emit3(8'h90, 8'h02, 8'h01);
   emit1(8'hF0);
   emit2(8'h80, 8'hFE);
   exp_q.push_back(r5 - 8'd1 + z);
   run_and_compare();
endtask

task automatic test_polled_loop();
   logic [7:0] n;
   logic [7:0] k;
   n = 8'd5;
   clear_image();
   emit3(8'h90, 8'h02, 8'h00);   // status address
   emit2(8'h7A, n);              // mov r2,#n
   emit1(8'hE0);                 // 0x005 movx a,@dptr
   emit2(8'h70, rel8(9'h008, 9'h005));   // spin while busy
   emit3(8'h90, 8'h02, 8'h01);
   emit1(8'hEA);                 // mov a,r2
   emit1(8'hF0);
   emit3(8'h90, 8'h02, 8'h00);
   emit2(8'hDA, rel8(9'h012, 9'h005));   // djnz r2
   emit2(8'h80, 8'hFE);
   for (k = n; k != 8'd0; k = k - 8'd1) exp_q.push_back(k);
   run_and_compare();
endtask

task automatic test_jumps();
   clear_image();
   emit3(8'h90, 8'h02, 8'h01);
   emit3(8'h02, 8'h01, 8'h20);   // ljmp 0x120
   emit2(8'h74, 8'hEE);          // skipped
   emit1(8'hF0);
   emit2(8'h80, 8'hFE);
   org(9'h120);
   emit1(8'hE4);                 // clr a
   emit2(8'h60, rel8(9'h123, 9'h126));   // jz, taken
   emit2(8'h74, 8'hDD);
   emit1(8'hF0);
   emit2(8'h70, rel8(9'h128, 9'h12D));   // 0x126 jnz, not taken
   emit2(8'h74, 8'h77);
   emit1(8'hF0);
   emit2(8'h80, 8'hFE);
   emit2(8'h74, 8'h22);          // 0x12d, only on a wrong jnz
   emit1(8'hF0);
   emit2(8'h80, 8'hFE);
   exp_q.push_back(8'h77);
   run_and_compare();
endtask

initial begin
   nrst       = 1'b0;
   rx_line    = 1'b1;
   line_watch = 1'b0;
   wr_ptr     = 9'd0;
   test_reset_and_load();
   test_const_tx();
   test_add();
   test_reg_moves();
   test_polled_loop();
   test_jumps();
   $display("No errors");
   $finish;
end

endmodule

`default_nettype wire

//--- vlog.f
src/ice51_pkg.sv
src/uart_rx.sv
src/code_store.sv
src/cpu_sequencer.sv
src/cpu_datapath.sv
src/uart_tx.sv
src/ice51_top.sv
testbench/tb_clock.sv
testbench/tb_top.sv
